// File: verilog/uart_spi_bridge_pkg.sv
// shared widths, timing constants and FSM encodings, imported by every bridge RTL block
package uart_spi_bridge_pkg;

  //////////////////////////////
  // data widths
  //////////////////////////////

  // one UART byte, also one SPI byte
  localparam int byte_w = 8;
  typedef logic [byte_w-1:0] byte_t;

  // address byte then data byte per transfer
  localparam int spi_word_w = 2 * byte_w;

  // bit index inside a byte
  localparam int bit_idx_w = $clog2(byte_w);

  //////////////////////////////
  // timing
  //////////////////////////////

  // sim value, board at 50 MHz / 115200 uses 434
  localparam int clks_per_bit = 8;
  localparam int clk_cnt_w = $clog2(clks_per_bit);

  // sck half period in sys_clk cycles
  localparam int spi_half_period = 4;
  localparam int spi_div_w = $clog2(spi_half_period);
  localparam int spi_bit_cnt_w = $clog2(spi_word_w);

  //////////////////////////////
  // reply queue
  //////////////////////////////

  localparam int queue_depth = 4;
  localparam int queue_ptr_w = 2;
  // count needs one extra bit to hold "full"
  localparam int queue_cnt_w = queue_ptr_w + 1;

  // serial FSM, shared by receiver and transmitter
  typedef enum logic [1:0] {uart_idle, uart_start, uart_data, uart_stop} uart_state_e;

  // SPI master FSM
  typedef enum logic [1:0] {spi_idle, spi_shift, spi_finish} spi_state_e;

endpackage

// File: verilog/uart_rx.sv
// 8N1 UART receiver, samples each bit at its middle and pulses rx_valid_o once per good byte
`timescale 1ns/1ps
module uart_rx (
  input  logic                       sys_clk,
  input  logic                       reset_all_cmd_w,
  input  logic                       uart_rx_i,
  output uart_spi_bridge_pkg::byte_t rx_byte_o,
  output logic                       rx_valid_o
);
  import uart_spi_bridge_pkg::*;

  // two-flop synchroniser on the async line
  logic rx_meta_q;
  logic rx_sync_q;

  uart_state_e          state_q;
  logic [clk_cnt_w-1:0] clk_cnt_q;
  logic [bit_idx_w-1:0] bit_idx_q;
  byte_t                shift_q;
  logic                 bit_end;
  logic                 half_bit;

  // full bit time, and half a bit for the start edge
  assign bit_end  = (clk_cnt_q == clk_cnt_w'(clks_per_bit - 1));
  assign half_bit = (clk_cnt_q == clk_cnt_w'(clks_per_bit / 2 - 1));

  // line idles high
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= uart_rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state_q    <= uart_idle;
      clk_cnt_q  <= '0;
      bit_idx_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      case (state_q)
        uart_idle: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          // falling edge opens the start bit
          if (!rx_sync_q) begin
            state_q <= uart_start;
          end
        end
        uart_start: begin
          if (half_bit) begin
            clk_cnt_q <= '0;
            // glitch if line went high again
            state_q   <= rx_sync_q ? uart_idle : uart_data;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        uart_data: begin
          if (bit_end) begin
            clk_cnt_q <= '0;
            // lsb first, shift in from the top
            shift_q   <= {rx_sync_q, shift_q[byte_w-1:1]};
            if (bit_idx_q == bit_idx_w'(byte_w - 1)) begin
              state_q <= uart_stop;
            end else begin
              bit_idx_q <= bit_idx_q + 1'b1;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        uart_stop: begin
          if (bit_end) begin
            state_q <= uart_idle;
            // framing error just drops the byte
            if (rx_sync_q) begin
              rx_valid_o <= 1'b1;
              rx_byte_o  <= shift_q;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: state_q <= uart_idle;
      endcase
    end
  end

endmodule

// File: verilog/uart_tx.sv
// 8N1 UART transmitter, sends one byte per tx_start_i pulse and flags when the line is busy
`timescale 1ns/1ps
module uart_tx (
  input  logic                       sys_clk,
  input  logic                       reset_all_cmd_w,
  input  uart_spi_bridge_pkg::byte_t tx_byte_i,
  input  logic                       tx_start_i,
  output logic                       uart_tx_o,
  output logic                       tx_active_o
);
  import uart_spi_bridge_pkg::*;

  uart_state_e          state_q;
  logic [clk_cnt_w-1:0] clk_cnt_q;
  logic [bit_idx_w-1:0] bit_idx_q;
  byte_t                shift_q;
  logic                 bit_end;

  assign bit_end = (clk_cnt_q == clk_cnt_w'(clks_per_bit - 1));

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state_q     <= uart_idle;
      clk_cnt_q   <= '0;
      bit_idx_q   <= '0;
      uart_tx_o   <= 1'b1;
      tx_active_o <= 1'b0;
    end else begin
      case (state_q)
        uart_idle: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          // start ignored unless idle
          if (tx_start_i) begin
            shift_q     <= tx_byte_i;
            uart_tx_o   <= 1'b0;
            tx_active_o <= 1'b1;
            state_q     <= uart_start;
          end
        end
        uart_start: begin
          if (bit_end) begin
            clk_cnt_q <= '0;
            // first data bit, lsb
            uart_tx_o <= shift_q[0];
            shift_q   <= shift_q >> 1;
            state_q   <= uart_data;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        uart_data: begin
          if (bit_end) begin
            clk_cnt_q <= '0;
            if (bit_idx_q == bit_idx_w'(byte_w - 1)) begin
              // stop bit
              uart_tx_o <= 1'b1;
              state_q   <= uart_stop;
            end else begin
              uart_tx_o <= shift_q[0];
              shift_q   <= shift_q >> 1;
              bit_idx_q <= bit_idx_q + 1'b1;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        uart_stop: begin
          // active drops only once the whole stop bit is out
          if (bit_end) begin
            tx_active_o <= 1'b0;
            state_q     <= uart_idle;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: state_q <= uart_idle;
      endcase
    end
  end

endmodule

// File: verilog/spi_master.sv
// mode-0 SPI master, shifts address then data MSB first and keeps the returned low byte
`timescale 1ns/1ps
module spi_master (
  input  logic                       sys_clk,
  input  logic                       reset_all_cmd_w,
  input  logic                       spi_start_i,
  input  uart_spi_bridge_pkg::byte_t addr_byte_i,
  input  uart_spi_bridge_pkg::byte_t data_byte_i,
  input  logic                       spi_miso_i,
  output logic                       spi_sen_o,
  output logic                       spi_sck_o,
  output logic                       spi_mosi_o,
  output logic                       spi_busy_o,
  output uart_spi_bridge_pkg::byte_t reply_byte_o
);
  import uart_spi_bridge_pkg::*;

  spi_state_e               state_q;
  logic [spi_div_w-1:0]     div_cnt_q;
  logic [spi_bit_cnt_w-1:0] bit_cnt_q;
  logic [spi_word_w-1:0]    tx_shift_q;
  logic [spi_word_w-1:0]    rx_shift_q;
  logic                     half_end;

  // end of each sck half period
  assign half_end = (div_cnt_q == spi_div_w'(spi_half_period - 1));

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state_q    <= spi_idle;
      div_cnt_q  <= '0;
      bit_cnt_q  <= '0;
      spi_sen_o  <= 1'b1;
      spi_sck_o  <= 1'b0;
      spi_mosi_o <= 1'b0;
      spi_busy_o <= 1'b0;
    end else begin
      case (state_q)
        spi_idle: begin
          div_cnt_q <= '0;
          bit_cnt_q <= '0;
          if (spi_start_i) begin
            // address goes out first
            tx_shift_q <= {addr_byte_i, data_byte_i};
            spi_mosi_o <= addr_byte_i[byte_w-1];
            spi_sen_o  <= 1'b0;
            spi_busy_o <= 1'b1;
            state_q    <= spi_shift;
          end
        end
        spi_shift: begin
          if (half_end) begin
            div_cnt_q <= '0;
            spi_sck_o <= ~spi_sck_o;
            if (!spi_sck_o) begin
              // rising edge, sample miso
              rx_shift_q <= {rx_shift_q[spi_word_w-2:0], spi_miso_i};
            end else if (bit_cnt_q == spi_bit_cnt_w'(spi_word_w - 1)) begin
              // last falling edge, sck back low
              state_q <= spi_finish;
            end else begin
              // falling edge, next bit onto mosi
              bit_cnt_q  <= bit_cnt_q + 1'b1;
              tx_shift_q <= tx_shift_q << 1;
              spi_mosi_o <= tx_shift_q[spi_word_w-2];
            end
          end else begin
            div_cnt_q <= div_cnt_q + 1'b1;
          end
        end
        spi_finish: begin
          // data phase reply sits in the low byte
          reply_byte_o <= rx_shift_q[byte_w-1:0];
          // sen and busy release together, marks the end
          spi_sen_o    <= 1'b1;
          spi_busy_o   <= 1'b0;
          spi_mosi_o   <= 1'b0;
          state_q      <= spi_idle;
        end
        default: state_q <= spi_idle;
      endcase
    end
  end

endmodule

// File: verilog/byte_pair_assembler.sv
// pairs the received byte stream into address and data, starting one SPI transfer per pair
`timescale 1ns/1ps
module byte_pair_assembler (
  input  logic                       sys_clk,
  input  logic                       reset_all_cmd_w,
  input  uart_spi_bridge_pkg::byte_t rx_byte_i,
  input  logic                       rx_valid_i,
  output uart_spi_bridge_pkg::byte_t addr_byte_o,
  output uart_spi_bridge_pkg::byte_t data_byte_o,
  output logic                       spi_start_o
);

  //////////////////////////////
  // pair parity
  //////////////////////////////

  // high while the first byte of a pair is held
  logic pair_odd_q;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      pair_odd_q  <= 1'b0;
      spi_start_o <= 1'b0;
    end else begin
      // second byte of a pair kicks the master
      spi_start_o <= rx_valid_i & pair_odd_q;
      if (rx_valid_i) begin
        pair_odd_q <= ~pair_odd_q;
      end
    end
  end

  //////////////////////////////
  // byte chain
  //////////////////////////////

  // older byte slides into the address slot
  always_ff @(posedge sys_clk) begin
    if (rx_valid_i) begin
      addr_byte_o <= data_byte_o;
      data_byte_o <= rx_byte_i;
    end
  end

endmodule

// File: verilog/reply_queue.sv
// four-entry reply queue, captures SPI replies at end of transfer and feeds the UART transmitter
`timescale 1ns/1ps
module reply_queue (
  input  logic                       sys_clk,
  input  logic                       reset_all_cmd_w,
  input  logic                       spi_busy_i,
  input  uart_spi_bridge_pkg::byte_t reply_byte_i,
  input  logic                       tx_active_i,
  output uart_spi_bridge_pkg::byte_t tx_byte_o,
  output logic                       tx_start_o
);
  import uart_spi_bridge_pkg::*;

  byte_t                  mem_q [queue_depth];
  logic [queue_ptr_w-1:0] wr_ptr_q;
  logic [queue_ptr_w-1:0] rd_ptr_q;
  logic [queue_cnt_w-1:0] count_q;
  logic                   busy_q;
  logic                   full;
  logic                   empty;
  logic                   wr_en;
  logic                   rd_en;

  assign full  = (count_q == queue_cnt_w'(queue_depth));
  assign empty = (count_q == '0);

  // busy falling edge, reply dropped when full
  assign wr_en = busy_q & ~spi_busy_i & ~full;
  // hold off while a start is still in flight to the transmitter
  assign rd_en = ~empty & ~tx_active_i & ~tx_start_o;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      busy_q     <= 1'b0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      tx_start_o <= 1'b0;
    end else begin
      busy_q     <= spi_busy_i;
      // start one cycle after the read
      tx_start_o <= rd_en;
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + queue_cnt_w'(wr_en) - queue_cnt_w'(rd_en);
    end
  end

  // storage and read data
  always_ff @(posedge sys_clk) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= reply_byte_i;
    end
    if (rd_en) begin
      tx_byte_o <= mem_q[rd_ptr_q];
    end
  end

endmodule

// File: verilog/uart_spi_bridge.sv
// top level of the UART-to-SPI command bridge, wires host UART through to the SPI slave and back
`timescale 1ns/1ps
module uart_spi_bridge (
  input  logic sys_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  input  logic spi_miso_i,
  output logic uart_tx_o,
  output logic spi_sen_o,
  output logic spi_sck_o,
  output logic spi_mosi_o
);
  import uart_spi_bridge_pkg::*;

  //////////////////////////////
  // host to SPI
  //////////////////////////////

  byte_t rx_byte;
  logic  rx_valid;
  byte_t addr_byte;
  byte_t data_byte;
  logic  spi_start;

  uart_rx i_uart_rx (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_i),
    .rx_byte_o       (rx_byte),
    .rx_valid_o      (rx_valid)
  );

  // every second byte launches a transfer
  byte_pair_assembler i_byte_pair_assembler (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_byte_i       (rx_byte),
    .rx_valid_i      (rx_valid),
    .addr_byte_o     (addr_byte),
    .data_byte_o     (data_byte),
    .spi_start_o     (spi_start)
  );

  //////////////////////////////
  // SPI and reply path
  //////////////////////////////

  logic  spi_busy;
  byte_t reply_byte;
  byte_t tx_byte;
  logic  tx_start;
  logic  tx_active;

  spi_master i_spi_master (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .spi_start_i     (spi_start),
    .addr_byte_i     (addr_byte),
    .data_byte_i     (data_byte),
    .spi_miso_i      (spi_miso_i),
    .spi_sen_o       (spi_sen_o),
    .spi_sck_o       (spi_sck_o),
    .spi_mosi_o      (spi_mosi_o),
    .spi_busy_o      (spi_busy),
    .reply_byte_o    (reply_byte)
  );

  // captures on busy fall, drains while uart is idle
  reply_queue i_reply_queue (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .spi_busy_i      (spi_busy),
    .reply_byte_i    (reply_byte),
    .tx_active_i     (tx_active),
    .tx_byte_o       (tx_byte),
    .tx_start_o      (tx_start)
  );

  uart_tx i_uart_tx (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .tx_byte_i       (tx_byte),
    .tx_start_i      (tx_start),
    .uart_tx_o       (uart_tx_o),
    .tx_active_o     (tx_active)
  );

endmodule

// File: test/uart_spi_bridge_sva.sv
// SPI master protocol assertions, attached to every spi_master by the bind at the bottom
`timescale 1ns/1ps
module uart_spi_bridge_sva (
  input logic sys_clk,
  input logic reset_all_cmd_w,
  input logic spi_start_i,
  input logic spi_busy_i,
  input logic spi_sen_i,
  input logic spi_sck_i
);

  // chip select low only inside a transfer
  sen_high_when_idle: assert property (@(posedge sys_clk) disable iff (reset_all_cmd_w)
    !spi_busy_i |-> spi_sen_i)
    else $error("spi_sen_o low while the master is idle");

  // start while idle, busy next cycle
  start_gives_busy: assert property (@(posedge sys_clk) disable iff (reset_all_cmd_w)
    spi_start_i && !spi_busy_i |=> spi_busy_i)
    else $error("start while idle did not raise busy");

  // mode 0 clock parks low
  sck_low_when_deselected: assert property (@(posedge sys_clk) disable iff (reset_all_cmd_w)
    spi_sen_i |-> !spi_sck_i)
    else $error("spi_sck_o high while chip select is high");

endmodule

bind spi_master uart_spi_bridge_sva i_uart_spi_bridge_sva (
  .sys_clk         (sys_clk),
  .reset_all_cmd_w (reset_all_cmd_w),
  .spi_start_i     (spi_start_i),
  .spi_busy_i      (spi_busy_o),
  .spi_sen_i       (spi_sen_o),
  .spi_sck_i       (spi_sck_o)
);

// File: test/uart_spi_bridge_tb.sv
// testbench for the UART-to-SPI bridge, sends host bytes and checks SPI transfers and replies
`timescale 1ns/1ps
module uart_spi_bridge_tb;
  import uart_spi_bridge_pkg::*;

  localparam int          byte_cycles = 10 * clks_per_bit;
  localparam int          wait_limit  = 40 * byte_cycles;
  localparam logic [15:0] lfsr_seed   = 16'd89;

  logic sys_clk;
  logic reset_all_cmd_w;
  logic uart_rx_i;
  logic spi_miso_i = 1'b0;
  logic uart_tx_o;
  logic spi_sen_o;
  logic spi_sck_o;
  logic spi_mosi_o;

  // expected and observed traffic
  logic [spi_word_w-1:0] exp_words [$];
  logic [spi_word_w-1:0] got_words [$];
  byte_t                 exp_replies [$];
  byte_t                 got_replies [$];
  // counted once compared
  int                    n_words = 0;
  int                    n_replies = 0;
  logic [15:0]           lfsr = lfsr_seed;

  // spi slave model state
  int                    slv_cnt = 0;
  logic                  sen_prev = 1'b1;
  logic                  sck_prev = 1'b0;
  logic [spi_word_w-1:0] slv_word = '0;
  byte_t                 slv_out = '0;

  // host receiver state
  logic                  mon_busy = 1'b0;
  int                    mon_cnt = 0;
  byte_t                 mon_byte = '0;

  uart_spi_bridge i_uart_spi_bridge (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_i),
    .spi_miso_i      (spi_miso_i),
    .uart_tx_o       (uart_tx_o),
    .spi_sen_o       (spi_sen_o),
    .spi_sck_o       (spi_sck_o),
    .spi_mosi_o      (spi_mosi_o)
  );

  initial begin
    sys_clk = 1'b0;
    forever #10 sys_clk = ~sys_clk;
  end

  //////////////////////////////
  // reference and helpers
  //////////////////////////////

  // slave register read returns address xor a5
  function automatic byte_t ref_reply(input byte_t addr);
    return addr ^ 8'ha5;
  endfunction

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic next_byte(output byte_t b);
    b = '0;
    for (int i = 0; i < byte_w; i++) begin
      lfsr = lfsr_step(lfsr);
      b = {b[byte_w-2:0], lfsr[0]};
    end
  endtask

  task automatic fail_value(input string sig, input logic [15:0] got, input logic [15:0] exp);
    $display("FAIL t=%0t %s got=%h exp=%h", $time, sig, got, exp);
    $display("** FAIL **");
    $fatal(1, "value mismatch");
  endtask

  task automatic fail_text(input string msg);
    $display("ERROR t=%0t %s", $time, msg);
    $display("** FAIL **");
    $fatal(1, "run stopped");
  endtask

  // host side, start bit, 8 data bits lsb first, stop bit
  task automatic send_byte(input byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge sys_clk);
      uart_rx_i <= frame[0];
      frame = frame >> 1;
      repeat (clks_per_bit - 1) @(posedge sys_clk);
    end
  endtask

  task automatic expect_pair(input byte_t addr, input byte_t data);
    exp_words.push_back({addr, data});
    exp_replies.push_back(ref_reply(addr));
  endtask

  task automatic send_pair(input byte_t addr, input byte_t data);
    expect_pair(addr, data);
    send_byte(addr);
    send_byte(data);
  endtask

  task automatic apply_reset();
    @(posedge sys_clk);
    reset_all_cmd_w <= 1'b1;
    repeat (8) @(posedge sys_clk);
    reset_all_cmd_w <= 1'b0;
  endtask

  // bridge quiet, no transfer and no reply
  task automatic check_idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge sys_clk);
      assert (spi_sen_o) else fail_value("spi_sen_o", {15'b0, spi_sen_o}, 16'h1);
      assert (!spi_sck_o) else fail_value("spi_sck_o", {15'b0, spi_sck_o}, 16'h0);
      assert (uart_tx_o) else fail_value("uart_tx_o", {15'b0, uart_tx_o}, 16'h1);
    end
  endtask

  task automatic wait_for_words(input int target);
    int cycles;
    cycles = 0;
    while (n_words < target) begin
      @(negedge sys_clk);
      cycles++;
      if (cycles > wait_limit) begin
        fail_text("timeout waiting for an SPI transfer");
      end
    end
  endtask

  task automatic wait_for_replies(input int target);
    int cycles;
    cycles = 0;
    while (n_replies < target) begin
      @(negedge sys_clk);
      cycles++;
      if (cycles > wait_limit) begin
        fail_text("timeout waiting for a reply byte on uart_tx_o");
      end
    end
  endtask

  //////////////////////////////
  // spi slave model
  //////////////////////////////

  // sck rise sampled half a cycle later
  always @(negedge sys_clk) begin
    if (reset_all_cmd_w) begin
      slv_cnt  = 0;
      sen_prev = 1'b1;
    end else if (spi_sen_o) begin
      if (!sen_prev) begin
        assert (slv_cnt == spi_word_w) else fail_text("SPI transfer had the wrong bit count");
        got_words.push_back(slv_word);
      end
      slv_cnt = 0;
    end else if (spi_sck_o && !sck_prev) begin
      slv_word = {slv_word[spi_word_w-2:0], spi_mosi_o};
      slv_cnt++;
      // address complete, load reply
      if (slv_cnt == byte_w) begin
        slv_out = ref_reply(slv_word[byte_w-1:0]);
      end else if (slv_cnt > byte_w) begin
        slv_out = slv_out << 1;
      end
    end
    sen_prev = reset_all_cmd_w ? 1'b1 : spi_sen_o;
    sck_prev = spi_sck_o;
  end

  // zeros in address phase, reply msb first after
  always @(posedge sys_clk) begin
    spi_miso_i <= (slv_cnt >= byte_w) ? slv_out[byte_w-1] : 1'b0;
  end

  //////////////////////////////
  // host receiver
  //////////////////////////////

  always @(negedge sys_clk) begin
    if (reset_all_cmd_w) begin
      mon_busy = 1'b0;
    end else if (!mon_busy) begin
      if (!uart_tx_o) begin
        mon_busy = 1'b1;
        mon_cnt  = 0;
      end
    end else begin
      mon_cnt++;
      // middle of each bit
      if (mon_cnt % clks_per_bit == clks_per_bit / 2) begin
        if (mon_cnt / clks_per_bit == 0) begin
          assert (!uart_tx_o) else fail_text("reply start bit did not stay low");
        end else if (mon_cnt / clks_per_bit <= byte_w) begin
          mon_byte = {uart_tx_o, mon_byte[byte_w-1:1]};
        end else begin
          assert (uart_tx_o) else fail_text("reply stop bit was not high");
          got_replies.push_back(mon_byte);
          mon_busy = 1'b0;
        end
      end
    end
  end

  //////////////////////////////
  // compare
  //////////////////////////////

  always @(posedge sys_clk) begin : compare_proc
    logic [spi_word_w-1:0] got_w;
    logic [spi_word_w-1:0] exp_w;
    byte_t                 got_r;
    byte_t                 exp_r;
    if (got_words.size() > 0) begin
      assert (exp_words.size() > 0) else fail_text("SPI transfer seen with none expected");
      got_w = got_words.pop_front();
      exp_w = exp_words.pop_front();
      assert (got_w == exp_w) else fail_value("spi_mosi_o", got_w, exp_w);
      n_words++;
    end
    if (got_replies.size() > 0) begin
      assert (exp_replies.size() > 0) else fail_text("reply byte seen with none expected");
      got_r = got_replies.pop_front();
      exp_r = exp_replies.pop_front();
      assert (got_r == exp_r) else fail_value("uart_tx_o", {8'h00, got_r}, {8'h00, exp_r});
      n_replies++;
    end
  end

  //////////////////////////////
  // sequence
  //////////////////////////////

  initial begin
    byte_t a;
    byte_t d;
    reset_all_cmd_w = 1'b1;
    uart_rx_i       = 1'b1;
    repeat (8) @(posedge sys_clk);
    reset_all_cmd_w <= 1'b0;

    // quiet after reset
    check_idle(3 * byte_cycles);

    // one pair, one transfer, one reply
    send_pair(8'h3c, 8'h5a);
    wait_for_words(1);
    wait_for_replies(1);
    check_idle(2 * byte_cycles);

    // back to back random pairs
    for (int k = 0; k < 12; k++) begin
      next_byte(a);
      next_byte(d);
      send_pair(a, d);
    end
    wait_for_words(13);
    wait_for_replies(13);

    // odd byte waits for its partner
    send_byte(8'hc3);
    check_idle(4 * byte_cycles);
    expect_pair(8'hc3, 8'h17);
    send_byte(8'h17);
    wait_for_words(14);
    wait_for_replies(14);

    // reset drops the held odd byte
    send_byte(8'h99);
    repeat (2 * clks_per_bit) @(posedge sys_clk);
    apply_reset();
    send_pair(8'h42, 8'he8);
    wait_for_words(15);
    wait_for_replies(15);

    // no stray transfer or reply afterwards
    check_idle(2 * byte_cycles);
    $display("** PASS **");
    $finish;
  end

endmodule

// File: project.f
verilog/uart_spi_bridge_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/spi_master.sv
verilog/byte_pair_assembler.sv
verilog/reply_queue.sv
verilog/uart_spi_bridge.sv
test/uart_spi_bridge_sva.sv
test/uart_spi_bridge_tb.sv

// File: Makefile
SRCS := $(shell cat project.f)

.PHONY: run clean

run: obj_dir/Vuart_spi_bridge_tb
	./obj_dir/Vuart_spi_bridge_tb | tee sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' sim.log; then echo "simulation did not finish"; exit 1; fi

obj_dir/Vuart_spi_bridge_tb: project.f $(SRCS)
	verilator --binary --timing --assert -f project.f --top-module uart_spi_bridge_tb

clean:
	rm -rf obj_dir sim.log
